/* list.f */
+incdir+verilog
verilog/rip_type.sv
verilog/rip_pipe_fifo.sv
verilog/rip_decode.sv
verilog/rip_decode_top.sv
verification/rip_tb_clock.sv
verification/rip_decode_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module rip_decode_tb \
    -o rip_sim \
    && ./obj_dir/rip_sim | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation status: ok" \
    || { echo "simulation status: bad"; exit 1; }

/* verification/rip_decode_tb.sv */
`timescale 1ns/1ps
`include "rip_defines.svh"

module rip_decode_tb;

    import rip_type::*;

    logic                           clk;
    logic                           rst_n;
    logic                           in_valid;
    logic                           in_ready;
    logic [`RIP_XLEN-1:0]           in_inst;
    logic                           out_valid;
    logic                           out_ready;
    inst_t                          out_inst;
    logic [`RIP_REG_ADDR_WIDTH-1:0] out_rs1_num;
    logic [`RIP_REG_ADDR_WIDTH-1:0] out_rs2_num;
    logic [`RIP_REG_ADDR_WIDTH-1:0] out_rd_num;
    logic [`RIP_CSR_ADDR_WIDTH-1:0] out_csr_num;
    logic [`RIP_REG_ADDR_WIDTH-1:0] out_csr_zimm;
    logic [`RIP_XLEN-1:0]           out_imm;

    // stimulus table, one slot per entry
    string                          t_name[$];
    logic [`RIP_XLEN-1:0]           t_word[$];
    inst_t                          t_inst[$];
    logic [`RIP_REG_ADDR_WIDTH-1:0] t_rs1[$];
    logic [`RIP_REG_ADDR_WIDTH-1:0] t_rs2[$];
    logic [`RIP_REG_ADDR_WIDTH-1:0] t_rd[$];
    logic [`RIP_CSR_ADDR_WIDTH-1:0] t_csr[$];
    logic [`RIP_REG_ADDR_WIDTH-1:0] t_zimm[$];
    logic [`RIP_XLEN-1:0]           t_imm[$];
    int                             n_entries = 0;
    int                             checked = 0;
    logic [31:0]                    lfsr_state = 32'h43be6740;

    rip_tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rip_decode_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_inst      (in_inst),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_inst     (out_inst),
        .out_rs1_num  (out_rs1_num),
        .out_rs2_num  (out_rs2_num),
        .out_rd_num   (out_rd_num),
        .out_csr_num  (out_csr_num),
        .out_csr_zimm (out_csr_zimm),
        .out_imm      (out_imm)
    );

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return lsb;
    endfunction

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int k = 0; k < count; k++) begin
            value = value * 2 + (next_random_bit() ? 1 : 0);
        end
        return value;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_inst(input string name, input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            $display("Error: %s inst expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_imm(input string name, input logic [`RIP_XLEN-1:0] expected,
                             input logic [`RIP_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s imm expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_reg_num(input string name,
                                 input logic [`RIP_REG_ADDR_WIDTH-1:0] expected,
                                 input logic [`RIP_REG_ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_csr(input string name, input logic [`RIP_CSR_ADDR_WIDTH-1:0] expected,
                             input logic [`RIP_CSR_ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s csr expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_bundle(input int i);
        check_inst(t_name[i], t_inst[i], out_inst);
        check_reg_num({t_name[i], " rs1"}, t_rs1[i], out_rs1_num);
        check_reg_num({t_name[i], " rs2"}, t_rs2[i], out_rs2_num);
        check_reg_num({t_name[i], " rd"}, t_rd[i], out_rd_num);
        check_csr(t_name[i], t_csr[i], out_csr_num);
        check_reg_num({t_name[i], " zimm"}, t_zimm[i], out_csr_zimm);
        check_imm(t_name[i], t_imm[i], out_imm);
    endtask

    task automatic add_entry(input string name, input logic [`RIP_XLEN-1:0] word,
                             input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [4:0] rd, input logic [11:0] csr,
                             input logic [4:0] zimm, input logic [31:0] imm,
                             input inst_t inst);
        t_name.push_back(name);
        t_word.push_back(word);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_rd.push_back(rd);
        t_csr.push_back(csr);
        t_zimm.push_back(zimm);
        t_imm.push_back(imm);
        t_inst.push_back(inst);
        n_entries = n_entries + 1;
    endtask

    // expected rs1, rs2, rd, csr, zimm and imm, then the flags
    task automatic build_table();
        add_entry("lui", {20'h12345, 5'd5, OPC_LUI},
                  5'd0, 5'd0, 5'd5, 12'h000, 5'd0, 32'h12345000,
                  inst_t'{LUI: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("auipc_x0", {20'hfffff, 5'd0, OPC_AUIPC},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'hfffff000,
                  inst_t'{AUIPC: 1'b1, default: 1'b0});
        add_entry("jal_neg", {20'hffdff, 5'd1, OPC_JAL},
                  5'd0, 5'd0, 5'd1, 12'h000, 5'd0, 32'hfffffffc,
                  inst_t'{JAL: 1'b1, UPDATE_REG: 1'b1, UPDATE_PC: 1'b1, default: 1'b0});
        add_entry("jalr", {12'h008, 5'd2, 3'b000, 5'd1, OPC_JALR},
                  5'd2, 5'd0, 5'd1, 12'h000, 5'd0, 32'h00000008,
                  inst_t'{JALR: 1'b1, UPDATE_REG: 1'b1, UPDATE_PC: 1'b1, default: 1'b0});
        add_entry("beq_neg", {7'h7f, 5'd2, 5'd1, 3'b000, 5'b11001, OPC_BRANCH},
                  5'd1, 5'd2, 5'd0, 12'h000, 5'd0, 32'hfffffff8,
                  inst_t'{BEQ: 1'b1, UPDATE_PC: 1'b1, default: 1'b0});
        add_entry("bgeu", {7'h00, 5'd4, 5'd3, 3'b111, 5'b10000, OPC_BRANCH},
                  5'd3, 5'd4, 5'd0, 12'h000, 5'd0, 32'h00000010,
                  inst_t'{BGEU: 1'b1, UPDATE_PC: 1'b1, default: 1'b0});
        add_entry("lw_neg", {12'hff4, 5'd7, 3'b010, 5'd6, OPC_LOAD},
                  5'd7, 5'd0, 5'd6, 12'h000, 5'd0, 32'hfffffff4,
                  inst_t'{LW: 1'b1, ACCESS_MEM: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("sw_neg", {7'h7f, 5'd10, 5'd11, 3'b010, 5'b01100, OPC_STORE},
                  5'd11, 5'd10, 5'd0, 12'h000, 5'd0, 32'hffffffec,
                  inst_t'{SW: 1'b1, ACCESS_MEM: 1'b1, default: 1'b0});
        add_entry("addi_neg", {12'hf9c, 5'd2, 3'b000, 5'd1, OPC_OP_IMM},
                  5'd2, 5'd0, 5'd1, 12'h000, 5'd0, 32'hffffff9c,
                  inst_t'{ADDI: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("nop", {12'h000, 5'd0, 3'b000, 5'd0, OPC_OP_IMM},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{ADDI: 1'b1, default: 1'b0});
        add_entry("slli", {7'h00, 5'd31, 5'd4, 3'b001, 5'd3, OPC_OP_IMM},
                  5'd4, 5'd0, 5'd3, 12'h000, 5'd0, 32'h0000001f,
                  inst_t'{SLLI: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("srli", {7'h00, 5'd16, 5'd6, 3'b101, 5'd5, OPC_OP_IMM},
                  5'd6, 5'd0, 5'd5, 12'h000, 5'd0, 32'h00000010,
                  inst_t'{SRLI: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        // funct7 bit must not leak into the shift amount
        add_entry("srai", {7'h20, 5'd7, 5'd6, 3'b101, 5'd5, OPC_OP_IMM},
                  5'd6, 5'd0, 5'd5, 12'h000, 5'd0, 32'h00000007,
                  inst_t'{SRAI: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("add", {7'h00, 5'd3, 5'd2, 3'b000, 5'd1, OPC_OP},
                  5'd2, 5'd3, 5'd1, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{ADD: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("sub", {7'h20, 5'd6, 5'd5, 3'b000, 5'd4, OPC_OP},
                  5'd5, 5'd6, 5'd4, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{SUB: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("sra", {7'h20, 5'd9, 5'd8, 3'b101, 5'd7, OPC_OP},
                  5'd8, 5'd9, 5'd7, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{SRA: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("mul", {7'h01, 5'd15, 5'd14, 3'b000, 5'd13, OPC_OP},
                  5'd14, 5'd15, 5'd13, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{MUL: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("divu", {7'h01, 5'd21, 5'd20, 3'b101, 5'd19, OPC_OP},
                  5'd20, 5'd21, 5'd19, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{DIVU: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("remu", {7'h01, 5'd24, 5'd23, 3'b111, 5'd22, OPC_OP},
                  5'd23, 5'd24, 5'd22, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{REMU: 1'b1, UPDATE_REG: 1'b1, default: 1'b0});
        add_entry("fence", {12'h0ff, 5'd0, 3'b000, 5'd0, OPC_MISC_MEM},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{FENCE: 1'b1, default: 1'b0});
        add_entry("fence_i", {12'h000, 5'd0, 3'b001, 5'd0, OPC_MISC_MEM},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{FENCE_I: 1'b1, default: 1'b0});
        add_entry("ecall", {12'h000, 5'd0, 3'b000, 5'd0, OPC_SYSTEM},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{ECALL: 1'b1, UPDATE_PC: 1'b1, default: 1'b0});
        add_entry("ebreak", {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{EBREAK: 1'b1, UPDATE_PC: 1'b1, default: 1'b0});
        add_entry("mret", {12'h302, 5'd0, 3'b000, 5'd0, OPC_SYSTEM},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{MRET: 1'b1, UPDATE_PC: 1'b1, default: 1'b0});
        add_entry("csrrw", {12'h300, 5'd2, 3'b001, 5'd1, OPC_SYSTEM},
                  5'd2, 5'd0, 5'd1, 12'h300, 5'd0, 32'h00000000,
                  inst_t'{CSRRW: 1'b1, UPDATE_REG: 1'b1, UPDATE_CSR: 1'b1,
                          default: 1'b0});
        add_entry("csrrs_x0", {12'h304, 5'd3, 3'b010, 5'd0, OPC_SYSTEM},
                  5'd3, 5'd0, 5'd0, 12'h304, 5'd0, 32'h00000000,
                  inst_t'{CSRRS: 1'b1, UPDATE_CSR: 1'b1, default: 1'b0});
        add_entry("csrrwi", {12'h340, 5'd17, 3'b101, 5'd5, OPC_SYSTEM},
                  5'd0, 5'd0, 5'd5, 12'h340, 5'd17, 32'h00000000,
                  inst_t'{CSRRWI: 1'b1, UPDATE_REG: 1'b1, UPDATE_CSR: 1'b1,
                          default: 1'b0});
        add_entry("csrrci", {12'h341, 5'd31, 3'b111, 5'd6, OPC_SYSTEM},
                  5'd0, 5'd0, 5'd6, 12'h341, 5'd31, 32'h00000000,
                  inst_t'{CSRRCI: 1'b1, UPDATE_REG: 1'b1, UPDATE_CSR: 1'b1,
                          default: 1'b0});
        // custom ops use no register fields
        add_entry("extx", {12'h000, 5'd8, 3'b000, 5'd7, OPC_CUSTOM0},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{EXTX: 1'b1, default: 1'b0});
        add_entry("ext", {12'h001, 5'd8, 3'b000, 5'd7, OPC_CUSTOM0},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000,
                  inst_t'{EXT: 1'b1, default: 1'b0});
        add_entry("unknown", {25'h1abcdef, 7'h7f},
                  5'd0, 5'd0, 5'd0, 12'h000, 5'd0, 32'h00000000, '0);
    endtask

    initial begin : stimulus
        int   sent;
        int   gap;
        logic in_fire;
        in_valid  = 1'b0;
        in_inst   = '0;
        out_ready = 1'b0;
        sent      = 0;
        in_fire   = 1'b0;
        build_table();
        @(posedge rst_n);
        #1;
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset in_ready", 1'b1, in_ready);
        gap = random_bits(2);
        while (checked < n_entries) begin
            @(negedge clk);
            if (in_fire) begin
                in_valid = 1'b0;
                sent = sent + 1;
                gap = random_bits(2);
            end
            if (!in_valid && sent < n_entries) begin
                if (gap == 0) begin
                    in_valid = 1'b1;
                    in_inst = t_word[sent];
                end else begin
                    gap = gap - 1;
                end
            end
            // roughly one cycle in four stalls the output side
            out_ready = random_bits(2) != 0;
            #1;
            in_fire = in_valid && in_ready;
        end
        out_ready = 1'b1;
        repeat (4) @(negedge clk);
        #1;
        check_bit("drain out_valid", 1'b0, out_valid);
        $display("Regression passed");
        $finish;
    end

    // outputs are settled here until the next rising edge
    initial begin : monitor
        forever begin
            @(negedge clk);
            #2;
            if (rst_n && out_valid && out_ready) begin
                if (checked >= n_entries) begin
                    $display("an extra output transfer appeared after the last table entry");
                    abort_run();
                end
                compare_bundle(checked);
                checked = checked + 1;
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat (n_entries * 60 + 5) @(posedge clk);
        $display("the decoded outputs stalled: only %0d of %0d entries came out in time",
                 checked, n_entries);
        abort_run();
    end

endmodule

/* verification/rip_tb_clock.sv */
`timescale 1ns/1ps

module rip_tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held over five rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verilog/rip_decode.sv */
`timescale 1ns/1ps
`include "rip_defines.svh"

module rip_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  rip_type::inst_word_u           in_inst,
    output logic                           out_valid,
    input  logic                           out_ready,
    output rip_type::inst_t                inst,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] rs1_num,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] rs2_num,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] rd_num,
    output logic [`RIP_CSR_ADDR_WIDTH-1:0] csr_num,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] csr_zimm,
    output logic [`RIP_XLEN-1:0]           imm
);

    import rip_type::*;

    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [`RIP_CSR_ADDR_WIDTH-1:0] funct12;
    logic r_type, i_type, s_type, b_type, u_type, j_type;
    logic csr_type, csr_i_type, shamt_form;
    logic [`RIP_REG_ADDR_WIDTH-1:0] next_rs1, next_rs2, next_rd, next_zimm;
    logic [`RIP_CSR_ADDR_WIDTH-1:0] next_csr;
    logic [`RIP_XLEN-1:0]           next_imm;
    inst_t                          next_inst;
    logic                           load;

    assign opcode  = in_inst.r_view.opcode;
    assign funct3  = in_inst.r_view.funct3;
    assign funct7  = in_inst.r_view.funct7;
    assign funct12 = in_inst.i_view.imm12;

    // format classes
    assign r_type = opcode == OPC_OP;
    assign i_type = opcode == OPC_LOAD || opcode == OPC_OP_IMM || opcode == OPC_JALR;
    assign s_type = opcode == OPC_STORE;
    assign b_type = opcode == OPC_BRANCH;
    assign u_type = opcode == OPC_LUI || opcode == OPC_AUIPC;
    assign j_type = opcode == OPC_JAL;
    assign csr_type   = opcode == OPC_SYSTEM && !funct3[2] && funct3[1:0] != 2'b00;
    assign csr_i_type = opcode == OPC_SYSTEM && funct3[2] && funct3[1:0] != 2'b00;
    // slli, srli, srai
    assign shamt_form = opcode == OPC_OP_IMM && funct3[1:0] == 2'b01;

    always_comb begin
        if (shamt_form) begin
            next_imm = {{(`RIP_XLEN - `RIP_REG_ADDR_WIDTH){1'b0}}, in_inst.r_view.rs2};
        end else if (i_type) begin
            next_imm = {{20{funct12[11]}}, funct12};
        end else if (s_type) begin
            next_imm = {{20{in_inst.s_view.imm_hi[6]}}, in_inst.s_view.imm_hi,
                        in_inst.s_view.imm_lo};
        end else if (b_type) begin
            next_imm = {{19{in_inst.s_view.imm_hi[6]}}, in_inst.s_view.imm_hi[6],
                        in_inst.s_view.imm_lo[0], in_inst.s_view.imm_hi[5:0],
                        in_inst.s_view.imm_lo[4:1], 1'b0};
        end else if (u_type) begin
            next_imm = {in_inst.u_view.imm20, 12'b0};
        end else if (j_type) begin
            next_imm = {{11{in_inst.u_view.imm20[19]}}, in_inst.u_view.imm20[19],
                        in_inst.u_view.imm20[7:0], in_inst.u_view.imm20[8],
                        in_inst.u_view.imm20[18:9], 1'b0};
        end else begin
            next_imm = '0;
        end
    end

    // only fields the format really has
    assign next_rd  = (r_type || i_type || u_type || j_type || csr_type || csr_i_type) ?
                      in_inst.r_view.rd : '0;
    assign next_rs1 = (r_type || i_type || s_type || b_type || csr_type) ?
                      in_inst.r_view.rs1 : '0;
    assign next_rs2 = (r_type || s_type || b_type) ? in_inst.r_view.rs2 : '0;
    assign next_csr  = (csr_type || csr_i_type) ? in_inst.i_view.imm12 : '0;
    assign next_zimm = csr_i_type ? in_inst.i_view.rs1 : '0;

    always_comb begin
        next_inst = '0;
        case (opcode)
            OPC_LUI:   next_inst.LUI   = 1'b1;
            OPC_AUIPC: next_inst.AUIPC = 1'b1;
            OPC_JAL:   next_inst.JAL   = 1'b1;
            OPC_JALR:  next_inst.JALR  = 1'b1;
            OPC_BRANCH: begin
                next_inst.BEQ  = funct3 == 3'b000;
                next_inst.BNE  = funct3 == 3'b001;
                next_inst.BLT  = funct3 == 3'b100;
                next_inst.BGE  = funct3 == 3'b101;
                next_inst.BLTU = funct3 == 3'b110;
                next_inst.BGEU = funct3 == 3'b111;
            end
            OPC_LOAD: begin
                next_inst.LB  = funct3 == 3'b000;
                next_inst.LH  = funct3 == 3'b001;
                next_inst.LW  = funct3 == 3'b010;
                next_inst.LBU = funct3 == 3'b100;
                next_inst.LHU = funct3 == 3'b101;
            end
            OPC_STORE: begin
                next_inst.SB = funct3 == 3'b000;
                next_inst.SH = funct3 == 3'b001;
                next_inst.SW = funct3 == 3'b010;
            end
            OPC_OP_IMM: begin
                next_inst.ADDI  = funct3 == 3'b000;
                next_inst.SLTI  = funct3 == 3'b010;
                next_inst.SLTIU = funct3 == 3'b011;
                next_inst.XORI  = funct3 == 3'b100;
                next_inst.ORI   = funct3 == 3'b110;
                next_inst.ANDI  = funct3 == 3'b111;
                next_inst.SLLI  = funct3 == 3'b001 && funct7 == 7'b0000000;
                next_inst.SRLI  = funct3 == 3'b101 && funct7 == 7'b0000000;
                next_inst.SRAI  = funct3 == 3'b101 && funct7 == 7'b0100000;
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    next_inst.ADD  = funct3 == 3'b000;
                    next_inst.SLL  = funct3 == 3'b001;
                    next_inst.SLT  = funct3 == 3'b010;
                    next_inst.SLTU = funct3 == 3'b011;
                    next_inst.XOR  = funct3 == 3'b100;
                    next_inst.SRL  = funct3 == 3'b101;
                    next_inst.OR   = funct3 == 3'b110;
                    next_inst.AND  = funct3 == 3'b111;
                end
                if (funct7 == 7'b0100000) begin
                    next_inst.SUB = funct3 == 3'b000;
                    next_inst.SRA = funct3 == 3'b101;
                end
                // RV32M shares the OP opcode
                if (funct7 == 7'b0000001) begin
                    next_inst.MUL    = funct3 == 3'b000;
                    next_inst.MULH   = funct3 == 3'b001;
                    next_inst.MULHSU = funct3 == 3'b010;
                    next_inst.MULHU  = funct3 == 3'b011;
                    next_inst.DIV    = funct3 == 3'b100;
                    next_inst.DIVU   = funct3 == 3'b101;
                    next_inst.REM    = funct3 == 3'b110;
                    next_inst.REMU   = funct3 == 3'b111;
                end
            end
            OPC_MISC_MEM: begin
                next_inst.FENCE   = funct3 == 3'b000;
                next_inst.FENCE_I = funct3 == 3'b001;
            end
            OPC_SYSTEM: begin
                next_inst.ECALL  = funct3 == 3'b000 && funct12 == 12'h000;
                next_inst.EBREAK = funct3 == 3'b000 && funct12 == 12'h001;
                next_inst.MRET   = funct3 == 3'b000 && funct12 == 12'h302;
                next_inst.CSRRW  = funct3 == 3'b001;
                next_inst.CSRRS  = funct3 == 3'b010;
                next_inst.CSRRC  = funct3 == 3'b011;
                next_inst.CSRRWI = funct3 == 3'b101;
                next_inst.CSRRSI = funct3 == 3'b110;
                next_inst.CSRRCI = funct3 == 3'b111;
            end
            OPC_CUSTOM0: begin
                next_inst.EXTX = funct12 == 12'h000;
                next_inst.EXT  = funct12 == 12'h001;
            end
            default: ;
        endcase

        next_inst.ACCESS_MEM = opcode == OPC_LOAD || opcode == OPC_STORE;
        // writes to x0 are dropped
        next_inst.UPDATE_REG = next_rd != '0;
        next_inst.UPDATE_CSR = csr_type || csr_i_type;
        next_inst.UPDATE_PC  = j_type || b_type || opcode == OPC_JALR ||
                               next_inst.ECALL || next_inst.EBREAK || next_inst.MRET;
    end

    // single-entry stage register
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            inst      <= '0;
            rs1_num   <= '0;
            rs2_num   <= '0;
            rd_num    <= '0;
            csr_num   <= '0;
            csr_zimm  <= '0;
            imm       <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            inst      <= next_inst;
            rs1_num   <= next_rs1;
            rs2_num   <= next_rs2;
            rd_num    <= next_rd;
            csr_num   <= next_csr;
            csr_zimm  <= next_zimm;
            imm       <= next_imm;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

/* verilog/rip_decode_top.sv */
`timescale 1ns/1ps
`include "rip_defines.svh"

module rip_decode_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [`RIP_XLEN-1:0]           in_inst,
    output logic                           out_valid,
    input  logic                           out_ready,
    output rip_type::inst_t                out_inst,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] out_rs1_num,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] out_rs2_num,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] out_rd_num,
    output logic [`RIP_CSR_ADDR_WIDTH-1:0] out_csr_num,
    output logic [`RIP_REG_ADDR_WIDTH-1:0] out_csr_zimm,
    output logic [`RIP_XLEN-1:0]           out_imm
);

    import rip_type::*;

    logic                           fetch_valid;
    logic                           fetch_ready;
    logic [`RIP_XLEN-1:0]           fetch_inst;
    logic                           dec_valid;
    logic                           dec_ready;
    inst_t                          dec_inst;
    logic [`RIP_REG_ADDR_WIDTH-1:0] dec_rs1_num;
    logic [`RIP_REG_ADDR_WIDTH-1:0] dec_rs2_num;
    logic [`RIP_REG_ADDR_WIDTH-1:0] dec_rd_num;
    logic [`RIP_CSR_ADDR_WIDTH-1:0] dec_csr_num;
    logic [`RIP_REG_ADDR_WIDTH-1:0] dec_csr_zimm;
    logic [`RIP_XLEN-1:0]           dec_imm;
    logic [`RIP_DEC_WIDTH-1:0]      issue_wr_data;
    logic [`RIP_DEC_WIDTH-1:0]      issue_rd_data;

    rip_pipe_fifo #(
        .WIDTH (`RIP_XLEN),
        .DEPTH (`RIP_FIFO_DEPTH)
    ) u_fetch_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (in_valid),
        .wr_ready (in_ready),
        .wr_data  (in_inst),
        .rd_valid (fetch_valid),
        .rd_ready (fetch_ready),
        .rd_data  (fetch_inst)
    );

    rip_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_ready  (fetch_ready),
        .in_inst   (fetch_inst),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .inst      (dec_inst),
        .rs1_num   (dec_rs1_num),
        .rs2_num   (dec_rs2_num),
        .rd_num    (dec_rd_num),
        .csr_num   (dec_csr_num),
        .csr_zimm  (dec_csr_zimm),
        .imm       (dec_imm)
    );

    // bundle packed in the same order it is unpacked
    assign issue_wr_data = {dec_inst, dec_rs1_num, dec_rs2_num, dec_rd_num,
                            dec_csr_num, dec_csr_zimm, dec_imm};

    rip_pipe_fifo #(
        .WIDTH (`RIP_DEC_WIDTH),
        .DEPTH (`RIP_FIFO_DEPTH)
    ) u_issue_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (dec_valid),
        .wr_ready (dec_ready),
        .wr_data  (issue_wr_data),
        .rd_valid (out_valid),
        .rd_ready (out_ready),
        .rd_data  (issue_rd_data)
    );

    assign {out_inst, out_rs1_num, out_rs2_num, out_rd_num,
            out_csr_num, out_csr_zimm, out_imm} = issue_rd_data;

endmodule

/* verilog/rip_defines.svh */
`ifndef RIP_DEFINES_SVH
`define RIP_DEFINES_SVH

// instruction and immediate width
`define RIP_XLEN 32

// register file and csr addressing
`define RIP_REG_ADDR_WIDTH 5
`define RIP_CSR_ADDR_WIDTH 12

// entries per pipe buffer
`define RIP_FIFO_DEPTH 2

// one flag bit per entry of rip_type::inst_t
`define RIP_INST_WIDTH 62

// inst, rs1, rs2, rd, csr number, zimm, imm
`define RIP_DEC_WIDTH (`RIP_INST_WIDTH + 3 * `RIP_REG_ADDR_WIDTH + `RIP_CSR_ADDR_WIDTH + \
    `RIP_REG_ADDR_WIDTH + `RIP_XLEN)

`endif

/* verilog/rip_pipe_fifo.sv */
`timescale 1ns/1ps

module rip_pipe_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_valid,
    output logic             wr_ready,
    input  logic [WIDTH-1:0] wr_data,
    output logic             rd_valid,
    input  logic             rd_ready,
    output logic [WIDTH-1:0] rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // full buffer still takes a word when one leaves this cycle
    assign wr_ready = (count != CNT_W'(DEPTH)) || rd_ready;
    assign rd_valid = count != '0;
    assign rd_data  = mem[rd_ptr];

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (push) begin
                mem[wr_ptr] <= wr_data;
                wr_ptr      <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* verilog/rip_type.sv */
`include "rip_defines.svh"

package rip_type;

    // major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
    localparam logic [6:0] OPC_CUSTOM0  = 7'b0001011;

    typedef struct packed {
        logic [6:0]                     funct7;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rs2;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                     funct3;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                     opcode;
    } r_view_t;

    // imm12 is the csr number, rs1 the zimm for csr forms
    typedef struct packed {
        logic [`RIP_CSR_ADDR_WIDTH-1:0] imm12;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                     funct3;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                     opcode;
    } i_view_t;

    // also used for B format
    typedef struct packed {
        logic [6:0]                     imm_hi;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rs2;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                     funct3;
        logic [4:0]                     imm_lo;
        logic [6:0]                     opcode;
    } s_view_t;

    // also used for J format
    typedef struct packed {
        logic [19:0]                    imm20;
        logic [`RIP_REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                     opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        s_view_t s_view;
        u_view_t u_view;
    } inst_word_u;

    typedef struct packed {
        // RV32I
        logic LUI, AUIPC, JAL, JALR;
        logic BEQ, BNE, BLT, BGE, BLTU, BGEU;
        logic LB, LH, LW, LBU, LHU;
        logic SB, SH, SW;
        logic ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI;
        logic ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND;
        logic FENCE, FENCE_I, ECALL, EBREAK, MRET;
        logic CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI;
        // RV32M
        logic MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU;
        // custom
        logic EXTX, EXT;
        // pipeline control
        logic ACCESS_MEM, UPDATE_REG, UPDATE_CSR, UPDATE_PC;
    } inst_t;

endpackage
